//--- rtl/core_macros.svh
//////////////////////////////////////////////////////////////////////
// bridge register addresses, data slot ids
// reset hold length and hsync delay
//////////////////////////////////////////////////////////////////////

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// core reset request
`define CORE_ADDR_RESET 32'h050

// video settings
`define CORE_ADDR_OVERSCAN 32'h200
`define CORE_ADDR_MASK 32'h204
`define CORE_ADDR_SPRITES 32'h208
`define CORE_ADDR_PALETTE 32'h20C
`define CORE_ADDR_SQUARE 32'h210

// input settings
`define CORE_ADDR_MULTITAP 32'h300
`define CORE_ADDR_LIGHTGUN 32'h304
`define CORE_ADDR_AIM 32'h308
`define CORE_ADDR_SWAP 32'h30C
`define CORE_ADDR_TURBO 32'h310

// data slot ids as given by the host
`define CORE_SLOT_ROM 16'd0
`define CORE_SLOT_PALETTE 16'd11

// cycles of clk_74a the core is held in reset
`define CORE_RESET_HOLD_CYCLES 32'h100000

// edges from hsync rise to the output pulse
`define CORE_HS_DELAY 3'd7

`endif

//--- rtl/core_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types for the console core top level
// settings fields, bridge bus words, video words and run states
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // bridge bus

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  //////////////////////////////////////////////////////////////////////
  // user settings

  // 0 off, 1 and 2 crop modes
  typedef logic [1:0] overscan_t;
  typedef logic [1:0] mask_t;
  typedef logic [2:0] palette_t;
  typedef logic [2:0] turbo_t;
  typedef logic [7:0] aim_speed_t;

  //////////////////////////////////////////////////////////////////////
  // data slots, video and reset hold

  typedef logic [15:0] slot_id_t;
  // r in 23:16, g in 15:8, b in 7:0
  typedef logic [23:0] rgb_t;
  // wide enough for the full hold length
  typedef logic [20:0] hold_count_t;

  // run state of the core
  typedef enum logic [1:0] {
    st_run,
    st_reset_hold,
    st_download
  } run_state_t;

endpackage

`default_nettype wire

//--- rtl/reset_hold_timer.sv
//////////////////////////////////////////////////////////////////////
// loadable down counter for the core reset hold
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module reset_hold_timer #(
  parameter core_pkg::hold_count_t HOLD_CYCLES = core_pkg::hold_count_t'(1)
) (
  input  wire  clk_74a,
  input  wire  pll_core_locked,
  input  wire  hold_load,
  output logic hold_done
);

  import core_pkg::*;

  // cycles left in the hold, idles at zero
  hold_count_t count;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count <= '0;
    end else if (hold_load) begin
      // reload beats the decrement
      count <= HOLD_CYCLES;
    end else if (count != hold_count_t'(0)) begin
      count <= count - hold_count_t'(1);
    end
  end

  // last cycle of the hold, count steps 1 -> 0 at the next edge
  assign hold_done = (count == hold_count_t'(1)) && !hold_load;

endmodule

`default_nettype wire

//--- rtl/core_settings_regs.sv
//////////////////////////////////////////////////////////////////////
// bridge write decode into the user setting registers
// effective mask and the core reset request strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_settings_regs (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire                         bridge_wr,
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,
  output logic                        reset_req,
  output core_pkg::overscan_t         hide_overscan,
  output core_pkg::mask_t             mask_eff,
  output logic                        allow_extra_sprites,
  output core_pkg::palette_t          selected_palette,
  output logic                        square_pixels,
  output logic                        multitap_enabled,
  output logic                        lightgun_enabled,
  output core_pkg::aim_speed_t        lightgun_aim_speed,
  output logic                        swap_controllers,
  output core_pkg::turbo_t            turbo_speed
);

  import core_pkg::*;

  // mask as written by the host
  mask_t mask_q;

  // one cycle strobe, same edge as the write
  assign reset_req = bridge_wr && (bridge_addr == `CORE_ADDR_RESET);

  // crop mode 2 hides the edges already, so no mask on top
  assign mask_eff = hide_overscan[1] ? mask_t'(0) : mask_q;

  //////////////////////////////////////////////////////////////////////
  // setting registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= '0;
      mask_q              <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      square_pixels       <= 1'b0;
      multitap_enabled    <= 1'b0;
      lightgun_enabled    <= 1'b0;
      lightgun_aim_speed  <= '0;
      swap_controllers    <= 1'b0;
      turbo_speed         <= '0;
    end else if (bridge_wr) begin
      // low bits of the word only, upper bits ignored
      case (bridge_addr)
        `CORE_ADDR_OVERSCAN: hide_overscan       <= bridge_wr_data[1:0];
        `CORE_ADDR_MASK:     mask_q              <= bridge_wr_data[1:0];
        `CORE_ADDR_SPRITES:  allow_extra_sprites <= bridge_wr_data[0];
        `CORE_ADDR_PALETTE:  selected_palette    <= bridge_wr_data[2:0];
        `CORE_ADDR_SQUARE:   square_pixels       <= bridge_wr_data[0];
        `CORE_ADDR_MULTITAP: multitap_enabled    <= bridge_wr_data[0];
        `CORE_ADDR_LIGHTGUN: lightgun_enabled    <= bridge_wr_data[0];
        `CORE_ADDR_AIM:      lightgun_aim_speed  <= bridge_wr_data[7:0];
        `CORE_ADDR_SWAP:     swap_controllers    <= bridge_wr_data[0];
        `CORE_ADDR_TURBO:    turbo_speed         <= bridge_wr_data[2:0];
        // reset address and unmapped writes leave settings alone
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/core_run_fsm.sv
//////////////////////////////////////////////////////////////////////
// run state machine of the core
// reset hold sequencing, download window and download kind decode
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_run_fsm (
  input  wire                     clk_74a,
  input  wire                     pll_core_locked,
  input  wire                     reset_req,
  input  wire                     hold_done,
  input  wire                     dataslot_requestwrite,
  input  wire core_pkg::slot_id_t dataslot_requestwrite_id,
  input  wire                     dataslot_allcomplete,
  output logic                    hold_load,
  output logic                    core_reset,
  output logic                    is_downloading,
  output logic                    rom_download,
  output logic                    palette_download
);

  import core_pkg::*;

  run_state_t state;
  // id of the slot being downloaded
  slot_id_t   slot_id_q;

  // timer starts on the same edge the state enters the hold
  assign hold_load = reset_req;

  //////////////////////////////////////////////////////////////////////
  // state register

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= st_run;
    end else if (reset_req) begin
      // a reset write wins and restarts a running hold
      state <= st_reset_hold;
    end else begin
      case (state)
        st_run: begin
          if (dataslot_requestwrite) begin
            state <= st_download;
          end
        end
        st_reset_hold: begin
          // requests seen here are dropped
          if (hold_done) begin
            state <= st_run;
          end
        end
        st_download: begin
          if (dataslot_allcomplete) begin
            state <= st_run;
          end
        end
        default: state <= st_run;
      endcase
    end
  end

  // capture the id with the request that opens the window
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      slot_id_q <= '0;
    end else if (state == st_run && dataslot_requestwrite && !reset_req) begin
      slot_id_q <= dataslot_requestwrite_id;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // outputs

  assign core_reset       = (state == st_reset_hold);
  assign is_downloading   = (state == st_download);
  assign rom_download     = is_downloading && (slot_id_q == `CORE_SLOT_ROM);
  assign palette_download = is_downloading && (slot_id_q == `CORE_SLOT_PALETTE);

endmodule

`default_nettype wire

//--- rtl/video_conditioner.sv
//////////////////////////////////////////////////////////////////////
// video output conditioning for the scaler
// registered data enable and rgb, slot word after active video
// single cycle hsync and vsync pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module video_conditioner (
  input  wire                      clk_74a,
  input  wire                      pll_core_locked,
  input  wire                      h_blank,
  input  wire                      v_blank,
  input  wire                      hs_in,
  input  wire                      vs_in,
  input  wire core_pkg::rgb_t      rgb_in,
  input  wire core_pkg::overscan_t hide_overscan,
  input  wire                      square_pixels,
  output core_pkg::rgb_t           video_rgb,
  output logic                     video_de,
  output logic                     video_hs,
  output logic                     video_vs
);

  import core_pkg::*;

  // active video when neither blank is set
  logic  de;
  // slot word, sent once per line at end of active video
  rgb_t  slot_word;

  // previous input levels for edge detect
  logic       hs_prev;
  logic       vs_prev;
  logic       de_prev;
  // edges left until the hsync pulse
  logic [2:0] hs_delay;

  assign de = !(h_blank || v_blank);

  // overscan in 15:14, square pixels in 13
  assign slot_word = {8'h00, hide_overscan, square_pixels, 13'h0000};

  //////////////////////////////////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      de_prev   <= 1'b0;
      hs_delay  <= '0;
    end else begin
      video_de <= de;

      // rgb is zero in blanking, except the slot word cycle
      if (de) begin
        video_rgb <= rgb_in;
      end else if (de_prev) begin
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end

      // hsync delay, a new rise restarts it
      if (hs_in && !hs_prev) begin
        hs_delay <= `CORE_HS_DELAY;
      end else if (hs_delay != 3'd0) begin
        hs_delay <= hs_delay - 3'd1;
      end
      video_hs <= (hs_delay == 3'd1);

      // vsync pulse on the rise, keeps clear of the delayed hsync
      video_vs <= vs_in && !vs_prev;

      hs_prev <= hs_in;
      vs_prev <= vs_in;
      de_prev <= de;
    end
  end

endmodule

`default_nettype wire

//--- rtl/core_top.sv
//////////////////////////////////////////////////////////////////////
// clk_74a side of the console core top level
// settings registers, run state machine, reset hold timer
// and video conditioning for the scaler
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module core_top #(
  parameter core_pkg::hold_count_t RESET_HOLD =
    core_pkg::hold_count_t'(`CORE_RESET_HOLD_CYCLES)
) (
  input  wire                      clk_74a,
  input  wire                      pll_core_locked,

  // bridge writes
  input  wire                      bridge_wr,
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,

  // data slot events from the host
  input  wire                      dataslot_requestwrite,
  input  wire core_pkg::slot_id_t  dataslot_requestwrite_id,
  input  wire                      dataslot_allcomplete,

  // raw video from the core
  input  wire                      h_blank,
  input  wire                      v_blank,
  input  wire                      hs_in,
  input  wire                      vs_in,
  input  wire core_pkg::rgb_t      rgb_in,

  // core control
  output wire                      core_reset,
  output wire                      rom_download,
  output wire                      palette_download,
  output wire                      is_downloading,

  // settings
  output wire core_pkg::mask_t     mask_eff,
  output wire core_pkg::overscan_t hide_overscan,
  output wire                      allow_extra_sprites,
  output wire core_pkg::palette_t  selected_palette,
  output wire                      multitap_enabled,
  output wire                      lightgun_enabled,
  output wire core_pkg::aim_speed_t lightgun_aim_speed,
  output wire                      swap_controllers,
  output wire core_pkg::turbo_t    turbo_speed,

  // video to the scaler
  output wire core_pkg::rgb_t      video_rgb,
  output wire                      video_de,
  output wire                      video_hs,
  output wire                      video_vs
);

  import core_pkg::*;

  // settings block to state machine
  logic reset_req;
  // state machine and timer handshake
  logic hold_load;
  logic hold_done;
  // only used by the video slot word
  logic square_pixels;

  //////////////////////////////////////////////////////////////////////
  // settings registers

  core_settings_regs u_settings (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_wr          (bridge_wr),
    .bridge_addr        (bridge_addr),
    .bridge_wr_data     (bridge_wr_data),
    .reset_req          (reset_req),
    .hide_overscan      (hide_overscan),
    .mask_eff           (mask_eff),
    .allow_extra_sprites(allow_extra_sprites),
    .selected_palette   (selected_palette),
    .square_pixels      (square_pixels),
    .multitap_enabled   (multitap_enabled),
    .lightgun_enabled   (lightgun_enabled),
    .lightgun_aim_speed (lightgun_aim_speed),
    .swap_controllers   (swap_controllers),
    .turbo_speed        (turbo_speed)
  );

  //////////////////////////////////////////////////////////////////////
  // reset hold and download tracking

  core_run_fsm u_run_fsm (
    .clk_74a                 (clk_74a),
    .pll_core_locked         (pll_core_locked),
    .reset_req               (reset_req),
    .hold_done               (hold_done),
    .dataslot_requestwrite   (dataslot_requestwrite),
    .dataslot_requestwrite_id(dataslot_requestwrite_id),
    .dataslot_allcomplete    (dataslot_allcomplete),
    .hold_load               (hold_load),
    .core_reset              (core_reset),
    .is_downloading          (is_downloading),
    .rom_download            (rom_download),
    .palette_download        (palette_download)
  );

  reset_hold_timer #(
    .HOLD_CYCLES(hold_count_t'(RESET_HOLD))
  ) u_hold_timer (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .hold_load      (hold_load),
    .hold_done      (hold_done)
  );

  //////////////////////////////////////////////////////////////////////
  // video

  video_conditioner u_video (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .h_blank        (h_blank),
    .v_blank        (v_blank),
    .hs_in          (hs_in),
    .vs_in          (vs_in),
    .rgb_in         (rgb_in),
    .hide_overscan  (hide_overscan),
    .square_pixels  (square_pixels),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 10 ns clk_74a, pll_core_locked low for the first 4 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_74a,
  output logic pll_core_locked
);

  // 100 MHz stand-in for the 74.25 MHz bridge clock
  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  // release just after the fourth rising edge
  initial begin
    pll_core_locked = 1'b0;
    repeat (4) @(posedge clk_74a);
    #1 pll_core_locked = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/core_top_checker.sv
//////////////////////////////////////////////////////////////////////
// concurrent assertions on the core_top outputs
// sync pulse width, reset and download exclusion
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module core_top_checker (
  input wire clk_74a,
  input wire pll_core_locked,
  input wire core_reset,
  input wire is_downloading,
  input wire video_hs,
  input wire video_vs
);

  // count of failed assertions
  int violations = 0;

  // syncs to the scaler are single cycle pulses
  hs_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else begin
      violations++;
      $error("video_hs high for two cycles");
    end

  vs_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else begin
      violations++;
      $error("video_vs high for two cycles");
    end

  // hold and download never open on the same edge
  hold_vs_download: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !($rose(core_reset) && $rose(is_downloading)))
    else begin
      violations++;
      $error("core_reset and is_downloading rose together");
    end

endmodule

`default_nettype wire

//--- verification/tb_core_top.sv
//////////////////////////////////////////////////////////////////////
// testbench for core_top
// cycle model of settings, run state and video compared every cycle
// directed and random tests, per test results and a watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "core_macros.svh"

module tb_core_top;

  import core_pkg::*;

  localparam int hold_len = 64;
  localparam int hs_delay = `CORE_HS_DELAY;
  // summed length of the tests in cycles for the watchdog
  localparam int test_cycles = 130 + 30 + 4 * hold_len + 2 * hold_len + 80 + 130 + 60;
  localparam int watchdog_ns = (test_cycles + 200) * 10;

  logic         clk_74a;
  logic         pll_core_locked;

  // dut inputs
  logic         bridge_wr;
  bridge_addr_t bridge_addr;
  bridge_data_t bridge_wr_data;
  logic         dataslot_requestwrite;
  slot_id_t     dataslot_requestwrite_id;
  logic         dataslot_allcomplete;
  logic         h_blank;
  logic         v_blank;
  logic         hs_in;
  logic         vs_in;
  rgb_t         rgb_in;

  // dut outputs
  logic         core_reset;
  logic         rom_download;
  logic         palette_download;
  logic         is_downloading;
  mask_t        mask_eff;
  overscan_t    hide_overscan;
  logic         allow_extra_sprites;
  palette_t     selected_palette;
  logic         multitap_enabled;
  logic         lightgun_enabled;
  aim_speed_t   lightgun_aim_speed;
  logic         swap_controllers;
  turbo_t       turbo_speed;
  rgb_t         video_rgb;
  logic         video_de;
  logic         video_hs;
  logic         video_vs;

  // reference model state
  overscan_t    exp_ovs = '0;
  mask_t        exp_mask = '0;
  logic         exp_sprites = 1'b0;
  palette_t     exp_palette = '0;
  logic         exp_square = 1'b0;
  logic         exp_multitap = 1'b0;
  logic         exp_lightgun = 1'b0;
  aim_speed_t   exp_aim = '0;
  logic         exp_swap = 1'b0;
  turbo_t       exp_turbo = '0;
  int           exp_hold = 0;
  logic         exp_dl = 1'b0;
  slot_id_t     exp_id = '0;
  rgb_t         exp_rgb = '0;
  logic         exp_de = 1'b0;
  logic         exp_hs = 1'b0;
  logic         exp_vs = 1'b0;
  // edges since the last hsync rise or -1 when idle
  int           hs_age = -1;
  logic         hs_last = 1'b0;
  logic         vs_last = 1'b0;

  // bookkeeping
  int error_count = 0;
  int test_base = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int pick;
  int ovs;
  int line;
  int cycles;
  int edges;
  slot_id_t other_id;

  bridge_addr_t setting_addrs [10] = '{`CORE_ADDR_OVERSCAN, `CORE_ADDR_MASK,
    `CORE_ADDR_SPRITES, `CORE_ADDR_PALETTE, `CORE_ADDR_SQUARE, `CORE_ADDR_MULTITAP,
    `CORE_ADDR_LIGHTGUN, `CORE_ADDR_AIM, `CORE_ADDR_SWAP, `CORE_ADDR_TURBO};
  // holes next to the mapped registers
  bridge_addr_t unmapped_addrs [4] = '{32'h214, 32'h314, 32'h054, 32'h1200};

  tb_clock_gen u_clock (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked)
  );

  core_top #(
    .RESET_HOLD(hold_len)
  ) u_dut (
    .clk_74a(clk_74a), .pll_core_locked(pll_core_locked),
    .bridge_wr(bridge_wr), .bridge_addr(bridge_addr), .bridge_wr_data(bridge_wr_data),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_requestwrite_id(dataslot_requestwrite_id),
    .dataslot_allcomplete(dataslot_allcomplete),
    .h_blank(h_blank), .v_blank(v_blank), .hs_in(hs_in), .vs_in(vs_in), .rgb_in(rgb_in),
    .core_reset(core_reset), .rom_download(rom_download),
    .palette_download(palette_download), .is_downloading(is_downloading),
    .mask_eff(mask_eff), .hide_overscan(hide_overscan),
    .allow_extra_sprites(allow_extra_sprites), .selected_palette(selected_palette),
    .multitap_enabled(multitap_enabled), .lightgun_enabled(lightgun_enabled),
    .lightgun_aim_speed(lightgun_aim_speed), .swap_controllers(swap_controllers),
    .turbo_speed(turbo_speed), .video_rgb(video_rgb), .video_de(video_de),
    .video_hs(video_hs), .video_vs(video_vs)
  );

  bind core_top core_top_checker u_checker (
    .clk_74a(clk_74a), .pll_core_locked(pll_core_locked),
    .core_reset(core_reset), .is_downloading(is_downloading),
    .video_hs(video_hs), .video_vs(video_vs)
  );

  //////////////////////////////////////////////////////////////////////
  // reference functions and model step

  // scaler word for one sampled pixel
  function automatic rgb_t expected_rgb(input logic de_now, input logic de_last,
                                        input rgb_t pix, input overscan_t ovs_set,
                                        input logic square_set);
    rgb_t word;
    word = '0;
    if (de_now) begin
      word = pix;
    end else if (de_last) begin
      // slot word on the first blank cycle
      word[15:14] = ovs_set;
      word[13] = square_set;
    end
    return word;
  endfunction

  // crop mode 2 and up turns the mask off
  function automatic mask_t expected_mask(input overscan_t ovs_set, input mask_t stored);
    return ovs_set[1] ? mask_t'(0) : stored;
  endfunction

  // advance the model by one clock edge with the inputs sampled there
  task automatic model_step();
    logic de_now;
    de_now = !(h_blank || v_blank);
    // video uses the settings from before this edge
    exp_rgb = expected_rgb(de_now, exp_de, rgb_in, exp_ovs, exp_square);
    exp_de = de_now;
    exp_vs = vs_in && !vs_last;
    if (hs_in && !hs_last) begin
      hs_age = 0;
    end else if (hs_age >= 0) begin
      hs_age = (hs_age < hs_delay) ? hs_age + 1 : -1;
    end
    exp_hs = (hs_age == hs_delay);
    hs_last = hs_in;
    vs_last = vs_in;

    // a reset write wins and requests during the hold are dropped
    if (bridge_wr && bridge_addr == `CORE_ADDR_RESET) begin
      exp_hold = hold_len;
      exp_dl = 1'b0;
    end else if (exp_hold > 0) begin
      exp_hold--;
    end else if (!exp_dl && dataslot_requestwrite) begin
      exp_dl = 1'b1;
      exp_id = dataslot_requestwrite_id;
    end else if (exp_dl && dataslot_allcomplete) begin
      exp_dl = 1'b0;
    end

    // settings take the low bits of the word
    if (bridge_wr) begin
      case (bridge_addr)
        `CORE_ADDR_OVERSCAN: exp_ovs = bridge_wr_data[1:0];
        `CORE_ADDR_MASK:     exp_mask = bridge_wr_data[1:0];
        `CORE_ADDR_SPRITES:  exp_sprites = bridge_wr_data[0];
        `CORE_ADDR_PALETTE:  exp_palette = bridge_wr_data[2:0];
        `CORE_ADDR_SQUARE:   exp_square = bridge_wr_data[0];
        `CORE_ADDR_MULTITAP: exp_multitap = bridge_wr_data[0];
        `CORE_ADDR_LIGHTGUN: exp_lightgun = bridge_wr_data[0];
        `CORE_ADDR_AIM:      exp_aim = bridge_wr_data[7:0];
        `CORE_ADDR_SWAP:     exp_swap = bridge_wr_data[0];
        `CORE_ADDR_TURBO:    exp_turbo = bridge_wr_data[2:0];
        default: begin
        end
      endcase
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("Fail %s got %h expected %h at %0t", name, got, want, $time);
      error_count++;
    end
  endtask

  task automatic compare_outputs();
    check_value("core_reset", core_reset, exp_hold > 0);
    check_value("is_downloading", is_downloading, exp_dl);
    check_value("rom_download", rom_download, exp_dl && exp_id == `CORE_SLOT_ROM);
    check_value("palette_download", palette_download,
                exp_dl && exp_id == `CORE_SLOT_PALETTE);
    check_value("hide_overscan", hide_overscan, exp_ovs);
    check_value("mask_eff", mask_eff, expected_mask(exp_ovs, exp_mask));
    check_value("allow_extra_sprites", allow_extra_sprites, exp_sprites);
    check_value("selected_palette", selected_palette, exp_palette);
    check_value("multitap_enabled", multitap_enabled, exp_multitap);
    check_value("lightgun_enabled", lightgun_enabled, exp_lightgun);
    check_value("lightgun_aim_speed", lightgun_aim_speed, exp_aim);
    check_value("swap_controllers", swap_controllers, exp_swap);
    check_value("turbo_speed", turbo_speed, exp_turbo);
    check_value("video_rgb", video_rgb, exp_rgb);
    check_value("video_de", video_de, exp_de);
    check_value("video_hs", video_hs, exp_hs);
    check_value("video_vs", video_vs, exp_vs);
  endtask

  // model steps on the edge and the dut is sampled mid cycle
  initial begin : compare_proc
    @(posedge pll_core_locked);
    forever begin
      @(posedge clk_74a);
      model_step();
      @(negedge clk_74a);
      compare_outputs();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers start and end 1 ns after a rising edge

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_74a);
      #1;
    end
  endtask

  task automatic bus_write(input bridge_addr_t addr, input bridge_data_t data);
    bridge_wr = 1'b1;
    bridge_addr = addr;
    bridge_wr_data = data;
    idle(1);
    bridge_wr = 1'b0;
  endtask

  // bounded count of cycles until core_reset drops
  task automatic measure_hold(output int held);
    held = 0;
    while (core_reset && held < 4 * hold_len) begin
      idle(1);
      held++;
    end
    assert (!core_reset) else begin
      $display("core_reset did not release within %0d cycles", held);
      error_count++;
    end
  endtask

  task automatic run_download(input slot_id_t id);
    int waited;
    dataslot_requestwrite = 1'b1;
    dataslot_requestwrite_id = id;
    idle(1);
    dataslot_requestwrite = 1'b0;
    waited = 0;
    while (!is_downloading && waited < 8) begin
      idle(1);
      waited++;
    end
    assert (is_downloading) else begin
      $display("download window did not open for slot id %h", id);
      error_count++;
    end
    idle(3 + $urandom % 6);
    dataslot_allcomplete = 1'b1;
    idle(1);
    dataslot_allcomplete = 1'b0;
    idle(2);
  endtask

  // edges from the sampled hsync rise to the output pulse
  task automatic hsync_delay(output int seen);
    hs_in = 1'b1;
    idle(1);
    seen = 0;
    while (!video_hs && seen < 16) begin
      idle(1);
      seen++;
      if (seen == 2) begin
        hs_in = 1'b0;
      end
    end
  endtask

  task automatic report_test(input string name);
    int n;
    idle(3);
    n = error_count - test_base;
    tests_run++;
    if (n == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, n);
    end
    test_base = error_count;
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests

  initial begin : stimulus
    void'($urandom(44));
    bridge_wr = 1'b0;
    bridge_addr = '0;
    bridge_wr_data = '0;
    dataslot_requestwrite = 1'b0;
    dataslot_requestwrite_id = '0;
    dataslot_allcomplete = 1'b0;
    h_blank = 1'b1;
    v_blank = 1'b0;
    hs_in = 1'b0;
    vs_in = 1'b0;
    rgb_in = '0;
    @(posedge pll_core_locked);
    idle(2);

    // random writes to mapped and unmapped addresses
    repeat (60) begin
      pick = $urandom % 14;
      if (pick < 10) begin
        bus_write(setting_addrs[pick], $urandom);
      end else begin
        bus_write(unmapped_addrs[pick - 10], $urandom);
      end
      if ($urandom % 3 == 0) begin
        idle(1);
      end
    end
    report_test("setting writes");

    // mask gating over every overscan mode
    for (ovs = 0; ovs < 4; ovs++) begin
      bus_write(`CORE_ADDR_OVERSCAN, ovs);
      bus_write(`CORE_ADDR_MASK, 1 + $urandom % 3);
      idle(2);
    end
    report_test("mask gating");

    // single hold then a hold extended by a second write
    bus_write(`CORE_ADDR_RESET, '0);
    measure_hold(cycles);
    assert (cycles == hold_len) else begin
      $display("core_reset held %0d cycles instead of %0d", cycles, hold_len);
      error_count++;
    end
    idle(4);
    bus_write(`CORE_ADDR_RESET, '0);
    idle(20);
    bus_write(`CORE_ADDR_RESET, '0);
    measure_hold(cycles);
    assert (cycles == hold_len) else begin
      $display("second reset write held %0d cycles instead of %0d", cycles, hold_len);
      error_count++;
    end
    report_test("reset hold");

    // rom, palette and another slot then a request inside a hold
    run_download(`CORE_SLOT_ROM);
    run_download(`CORE_SLOT_PALETTE);
    do begin
      other_id = $urandom;
    end while (other_id == `CORE_SLOT_ROM || other_id == `CORE_SLOT_PALETTE);
    run_download(other_id);
    bus_write(`CORE_ADDR_RESET, '0);
    idle(4);
    dataslot_requestwrite = 1'b1;
    dataslot_requestwrite_id = `CORE_SLOT_ROM;
    idle(1);
    dataslot_requestwrite = 1'b0;
    idle(2);
    assert (!is_downloading) else begin
      $display("download window opened during the reset hold");
      error_count++;
    end
    measure_hold(cycles);
    report_test("download tracking");

    // lines of random pixels with the last one inside vertical blank
    bus_write(`CORE_ADDR_OVERSCAN, 2);
    bus_write(`CORE_ADDR_SQUARE, 1);
    for (line = 0; line < 6; line++) begin
      if (line == 3) begin
        bus_write(`CORE_ADDR_OVERSCAN, 1);
      end
      v_blank = (line == 5);
      h_blank = 1'b0;
      repeat (4 + $urandom % 9) begin
        rgb_in = $urandom;
        idle(1);
      end
      h_blank = 1'b1;
      repeat (3 + $urandom % 4) begin
        rgb_in = $urandom;
        idle(1);
      end
    end
    v_blank = 1'b0;
    rgb_in = '0;
    report_test("video frames");

    // vsync pulse on the sampling edge
    vs_in = 1'b1;
    idle(1);
    assert (video_vs) else begin
      $display("video_vs did not pulse on the vsync rise");
      error_count++;
    end
    idle(3);
    vs_in = 1'b0;
    // plain hsync delay then a rise that restarts it
    hsync_delay(edges);
    assert (edges == 7) else begin
      $display("video_hs came %0d edges after the hsync rise, not 7", edges);
      error_count++;
    end
    idle(10);
    hs_in = 1'b1;
    idle(1);
    hs_in = 1'b0;
    idle(2);
    hsync_delay(edges);
    assert (edges == 7) else begin
      $display("restarted hsync pulse came after %0d edges, not 7", edges);
      error_count++;
    end
    idle(10);
    report_test("sync pulses");

    assert (u_dut.u_checker.violations == 0) else begin
      $display("bound checker saw %0d assertion failures", u_dut.u_checker.violations);
      error_count++;
    end
    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run length bound
  initial begin : watchdog
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/core_pkg.sv
rtl/reset_hold_timer.sv
rtl/core_settings_regs.sv
rtl/core_run_fsm.sv
rtl/video_conditioner.sv
rtl/core_top.sv
verification/tb_clock_gen.sv
verification/core_top_checker.sv
verification/tb_core_top.sv
